// File: Makefile
SIM       = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_audio_engine
FILELIST  = src.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = FAIL: see errors above
PASS_MSG  = PASS: all tests

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not complete"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: audio_engine.sv
`timescale 1ns/1ps

module audio_engine #(
    parameter audio_pkg::cs_t BASE_ADDR = 8'h60,
    parameter int I2S_DIVIDER = 16
) (
    input  logic              ck,
    input  logic              arst_n,
    input  logic              bus_cyc,
    input  logic              bus_we,
    input  audio_pkg::word_t  bus_adr,
    input  audio_pkg::word_t  bus_dat,
    input  logic              sd_in0,
    input  logic              sd_in1,
    input  logic              sd_in2,
    input  logic              sd_in3,
    output logic              ack,
    output audio_pkg::word_t  rdt,
    output logic              sck,
    output logic              ws,
    output logic              sd_out,
    output logic              ready
);

    logic                   bit_en;
    logic                   sample_en;
    audio_pkg::posn_t       frame_posn;
    audio_pkg::sample_t     mic [audio_pkg::CHANNELS];
    audio_pkg::sample_t     mon_left;
    audio_pkg::sample_t     mon_right;
    logic                   ram_we;
    audio_pkg::audio_addr_t ram_waddr;
    audio_pkg::audio_addr_t ram_raddr;
    audio_pkg::sample_t     ram_wdata;
    audio_pkg::sample_t     ram_rdata;
    audio_pkg::frame_t      frame;
    audio_pkg::frame_t      capture_count;
    logic                   host_we;
    audio_pkg::audio_addr_t host_addr;
    audio_pkg::sample_t     host_data;
    logic                   host_mode;
    audio_pkg::chan_t       left_sel;
    audio_pkg::chan_t       right_sel;

    i2s_timing #(.I2S_DIVIDER(I2S_DIVIDER)) i_i2s_timing (
        .ck(ck), .arst_n(arst_n), .sck(sck), .ws(ws), .bit_en(bit_en),
        .sample_en(sample_en), .frame_posn(frame_posn)
    );

    // Each stereo line carries an even/odd channel pair
    i2s_rx i_i2s_rx0 (
        .ck(ck), .arst_n(arst_n), .sample_en(sample_en), .sd(sd_in0),
        .frame_posn(frame_posn), .left(mic[0]), .right(mic[1])
    );
    i2s_rx i_i2s_rx1 (
        .ck(ck), .arst_n(arst_n), .sample_en(sample_en), .sd(sd_in1),
        .frame_posn(frame_posn), .left(mic[2]), .right(mic[3])
    );
    i2s_rx i_i2s_rx2 (
        .ck(ck), .arst_n(arst_n), .sample_en(sample_en), .sd(sd_in2),
        .frame_posn(frame_posn), .left(mic[4]), .right(mic[5])
    );
    i2s_rx i_i2s_rx3 (
        .ck(ck), .arst_n(arst_n), .sample_en(sample_en), .sd(sd_in3),
        .frame_posn(frame_posn), .left(mic[6]), .right(mic[7])
    );

    i2s_tx i_i2s_tx (
        .ck(ck), .arst_n(arst_n), .bit_en(bit_en), .frame_posn(frame_posn),
        .left(mon_left), .right(mon_right), .sd(sd_out)
    );

    frame_capture i_frame_capture (
        .ck(ck), .arst_n(arst_n), .bit_en(bit_en), .frame_posn(frame_posn),
        .host_mode(host_mode), .mic(mic), .left_sel(left_sel), .right_sel(right_sel),
        .host_we(host_we), .host_addr(host_addr), .host_data(host_data),
        .ram_we(ram_we), .ram_waddr(ram_waddr), .ram_wdata(ram_wdata),
        .frame(frame), .capture_count(capture_count),
        .mon_left(mon_left), .mon_right(mon_right), .ready(ready)
    );

    audio_ram i_audio_ram (
        .ck(ck), .we(ram_we), .waddr(ram_waddr), .raddr(ram_raddr),
        .wdata(ram_wdata), .rdata(ram_rdata)
    );

    host_regs #(.BASE_ADDR(BASE_ADDR)) i_host_regs (
        .ck(ck), .arst_n(arst_n), .bus_cyc(bus_cyc), .bus_we(bus_we),
        .bus_adr(bus_adr), .bus_dat(bus_dat), .ram_rdata(ram_rdata),
        .frame(frame), .capture_count(capture_count), .ack(ack), .rdt(rdt),
        .ram_raddr(ram_raddr), .host_addr(host_addr), .host_we(host_we),
        .host_data(host_data), .host_mode(host_mode),
        .left_sel(left_sel), .right_sel(right_sel)
    );

endmodule

// File: audio_engine_properties.sv
`timescale 1ns/1ps

module audio_engine_properties (
    input logic                   ck,
    input logic                   arst_n,
    input logic                   bus_cyc,
    input logic                   bus_we,
    input audio_pkg::word_t       bus_adr,
    input audio_pkg::word_t       bus_dat,
    input logic                   ack,
    input audio_pkg::word_t       rdt,
    input logic                   ready,
    input logic                   host_mode,
    input logic                   ram_we,
    input audio_pkg::audio_addr_t ram_waddr,
    input audio_pkg::sample_t     ram_wdata
);

    // One ack per request
    ack_pulse: assert property (@(posedge ck) disable iff (!arst_n) ack |=> !ack)
        else $error("ack high on two cycles in a row");

    ready_pulse: assert property (@(posedge ck) disable iff (!arst_n) ready |=> !ready)
        else $error("ready longer than one cycle");

    // In host mode every RAM write comes from a bus write cycle
    host_owns_ram: assert property (@(posedge ck) disable iff (!arst_n)
        (host_mode && ram_we) |-> (bus_cyc && bus_we && (ram_waddr == bus_adr[12:2])
            && (ram_wdata == bus_dat[15:0])))
        else $error("capture write while host mode is set");

    rdt_idle_zero: assert property (@(posedge ck) disable iff (!arst_n)
        !ack |-> (rdt == '0))
        else $error("rdt not zero while ack is low");

endmodule

bind audio_engine audio_engine_properties i_audio_engine_properties (
    .ck(ck), .arst_n(arst_n), .bus_cyc(bus_cyc), .bus_we(bus_we),
    .bus_adr(bus_adr), .bus_dat(bus_dat), .ack(ack), .rdt(rdt), .ready(ready),
    .host_mode(host_mode), .ram_we(ram_we), .ram_waddr(ram_waddr),
    .ram_wdata(ram_wdata)
);

// File: audio_pkg.sv
package audio_pkg;

    // Array geometry
    localparam int CHANNELS = 8;
    localparam int FRAMES = 256;
    localparam int SAMPLE_W = 16;

    // Index widths follow from the geometry
    localparam int CHAN_W = $clog2(CHANNELS);
    localparam int FRAME_W = $clog2(FRAMES);
    localparam int AUDIO_W = CHAN_W + FRAME_W;

    // Bit slots per I2S frame
    localparam int POSN_W = 6;

    typedef logic [CHAN_W-1:0] chan_t;
    typedef logic [FRAME_W-1:0] frame_t;

    // Channel in the upper bits, frame index in the lower bits
    typedef logic [AUDIO_W-1:0] audio_addr_t;

    typedef logic [SAMPLE_W-1:0] sample_t;
    typedef logic [POSN_W-1:0] posn_t;

    // Host bus
    typedef logic [31:0] word_t;
    typedef logic [7:0] cs_t;

    // Window offsets from the base chip-select byte
    localparam cs_t OFFSET_STATUS = 8'h02;
    localparam cs_t OFFSET_AUDIO = 8'h04;

    // Frame capture FSM
    typedef enum logic {
        IDLE,
        WRITE
    } capture_state_t;

endpackage

// File: audio_ram.sv
`timescale 1ns/1ps

module audio_ram (
    input  logic                    ck,
    input  logic                    we,
    input  audio_pkg::audio_addr_t  waddr,
    input  audio_pkg::audio_addr_t  raddr,
    input  audio_pkg::sample_t      wdata,
    output audio_pkg::sample_t      rdata
);

    localparam int DEPTH = audio_pkg::CHANNELS * audio_pkg::FRAMES;

    audio_pkg::sample_t mem [DEPTH];

    always_ff @(posedge ck) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // One cycle read latency
    always_ff @(posedge ck) begin
        rdata <= mem[raddr];
    end

endmodule

// File: frame_capture.sv
`timescale 1ns/1ps

module frame_capture (
    input  logic                       ck,
    input  logic                       arst_n,
    input  logic                       bit_en,
    input  audio_pkg::posn_t           frame_posn,
    input  logic                       host_mode,
    input  audio_pkg::sample_t         mic [audio_pkg::CHANNELS],
    input  audio_pkg::chan_t           left_sel,
    input  audio_pkg::chan_t           right_sel,
    input  logic                       host_we,
    input  audio_pkg::audio_addr_t     host_addr,
    input  audio_pkg::sample_t         host_data,
    output logic                       ram_we,
    output audio_pkg::audio_addr_t     ram_waddr,
    output audio_pkg::sample_t         ram_wdata,
    output audio_pkg::frame_t          frame,
    output audio_pkg::frame_t          capture_count,
    output audio_pkg::sample_t         mon_left,
    output audio_pkg::sample_t         mon_right,
    output logic                       ready
);

    audio_pkg::capture_state_t state_q;
    audio_pkg::chan_t          chan_q;
    audio_pkg::sample_t        cur_sample;
    logic                      start_of_frame;
    logic                      cap_we;
    logic                      last_chan;

    assign start_of_frame = bit_en && (frame_posn == 6'd0);
    assign cur_sample = mic[chan_q];
    assign last_chan = (chan_q == audio_pkg::chan_t'(audio_pkg::CHANNELS - 1));

    // Capture stops writing at once when the host takes over
    assign cap_we = (state_q == audio_pkg::WRITE) && !host_mode;

    always_ff @(posedge ck or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= audio_pkg::IDLE;
            chan_q <= '0;
            frame <= '0;
            capture_count <= '0;
            ready <= 1'b0;
        end else begin
            ready <= 1'b0;
            case (state_q)
                audio_pkg::IDLE: begin
                    if (start_of_frame && !host_mode) begin
                        frame <= frame - 1'b1;
                        chan_q <= '0;
                        state_q <= audio_pkg::WRITE;
                    end
                end
                audio_pkg::WRITE: begin
                    if (host_mode) begin
                        // Abandoned frame, no ready
                        state_q <= audio_pkg::IDLE;
                    end else if (last_chan) begin
                        state_q <= audio_pkg::IDLE;
                        ready <= 1'b1;
                        capture_count <= capture_count + 1'b1;
                    end else begin
                        chan_q <= chan_q + 1'b1;
                    end
                end
                default: state_q <= audio_pkg::IDLE;
            endcase
        end
    end

    // Monitor channels pick up their sample as it goes to the RAM
    always_ff @(posedge ck or negedge arst_n) begin
        if (!arst_n) begin
            mon_left <= '0;
            mon_right <= '0;
        end else if (cap_we) begin
            if (chan_q == left_sel) begin
                mon_left <= cur_sample;
            end
            if (chan_q == right_sel) begin
                mon_right <= cur_sample;
            end
        end
    end

    // Host owns the write port in host mode
    assign ram_we = host_mode ? host_we : cap_we;
    assign ram_waddr = host_mode ? host_addr : {chan_q, frame};
    assign ram_wdata = host_mode ? host_data : cur_sample;

endmodule

// File: host_regs.sv
`timescale 1ns/1ps

module host_regs #(
    parameter audio_pkg::cs_t BASE_ADDR = 8'h60
) (
    input  logic                    ck,
    input  logic                    arst_n,
    input  logic                    bus_cyc,
    input  logic                    bus_we,
    input  audio_pkg::word_t        bus_adr,
    input  audio_pkg::word_t        bus_dat,
    input  audio_pkg::sample_t      ram_rdata,
    input  audio_pkg::frame_t       frame,
    input  audio_pkg::frame_t       capture_count,
    output logic                    ack,
    output audio_pkg::word_t        rdt,
    output audio_pkg::audio_addr_t  ram_raddr,
    output audio_pkg::audio_addr_t  host_addr,
    output logic                    host_we,
    output audio_pkg::sample_t      host_data,
    output logic                    host_mode,
    output audio_pkg::chan_t        left_sel,
    output audio_pkg::chan_t        right_sel
);

    localparam audio_pkg::cs_t CS_STATUS = audio_pkg::cs_t'(BASE_ADDR + audio_pkg::OFFSET_STATUS);
    localparam audio_pkg::cs_t CS_AUDIO = audio_pkg::cs_t'(BASE_ADDR + audio_pkg::OFFSET_AUDIO);

    audio_pkg::cs_t   cs;
    logic             status_hit;
    logic             audio_hit;
    logic             req;
    logic [1:0]       word_sel;
    logic [6:0]       ctrl_q;
    audio_pkg::word_t status_rdata;

    assign cs = bus_adr[31:24];
    assign status_hit = (cs == CS_STATUS);
    assign audio_hit = (cs == CS_AUDIO);
    assign word_sel = bus_adr[3:2];

    // First cycle of a decoded request, ack follows on the next
    assign req = bus_cyc && (status_hit || audio_hit) && !ack;

    always_ff @(posedge ck or negedge arst_n) begin
        if (!arst_n) begin
            ack <= 1'b0;
        end else begin
            ack <= req;
        end
    end

    // Control: bit 0 host mode, 3:1 left select, 6:4 right select
    always_ff @(posedge ck or negedge arst_n) begin
        if (!arst_n) begin
            ctrl_q <= '0;
        end else if (req && bus_we && status_hit && (word_sel == 2'd0)) begin
            ctrl_q <= bus_dat[6:0];
        end
    end

    assign host_mode = ctrl_q[0];
    assign left_sel = ctrl_q[3:1];
    assign right_sel = ctrl_q[6:4];

    // Audio window, address taken straight off the bus
    assign ram_raddr = bus_adr[12:2];
    assign host_addr = bus_adr[12:2];
    assign host_data = bus_dat[15:0];
    assign host_we = req && bus_we && audio_hit;

    always_comb begin
        case (word_sel)
            2'd0: status_rdata = {25'd0, ctrl_q};
            2'd1: status_rdata = {15'd0, host_mode, capture_count, frame};
            default: status_rdata = '0;
        endcase
    end

    always_comb begin
        rdt = '0;
        if (ack && !bus_we) begin
            if (audio_hit) begin
                rdt = {16'd0, ram_rdata};
            end else if (status_hit) begin
                rdt = status_rdata;
            end
        end
    end

endmodule

// File: i2s_rx.sv
`timescale 1ns/1ps

module i2s_rx (
    input  logic                ck,
    input  logic                arst_n,
    input  logic                sample_en,
    input  logic                sd,
    input  audio_pkg::posn_t    frame_posn,
    output audio_pkg::sample_t  left,
    output audio_pkg::sample_t  right
);

    audio_pkg::sample_t shift_q;
    logic               data_slot;
    logic               last_slot;

    // Slots 1..16 of each half carry data, MSB first
    assign data_slot = (frame_posn[4:0] != 5'd0) && (frame_posn[4:0] <= 5'd16);
    assign last_slot = (frame_posn[4:0] == 5'd16);

    always_ff @(posedge ck) begin
        if (sample_en && data_slot) begin
            shift_q <= {shift_q[14:0], sd};
        end
    end

    always_ff @(posedge ck or negedge arst_n) begin
        if (!arst_n) begin
            left <= '0;
            right <= '0;
        end else if (sample_en && last_slot) begin
            // ws half selects the destination word
            if (frame_posn[5]) begin
                right <= {shift_q[14:0], sd};
            end else begin
                left <= {shift_q[14:0], sd};
            end
        end
    end

endmodule

// File: i2s_timing.sv
`timescale 1ns/1ps

module i2s_timing #(
    parameter int I2S_DIVIDER = 16
) (
    input  logic               ck,
    input  logic               arst_n,
    output logic               sck,
    output logic               ws,
    output logic               bit_en,
    output logic               sample_en,
    output audio_pkg::posn_t   frame_posn
);

    localparam int DIV_W = $clog2(I2S_DIVIDER);
    // Sampling point sits a third of a bit period after the data edge
    localparam int DLY = I2S_DIVIDER / 3;

    logic [DIV_W-1:0] div_cnt;
    logic [DLY-1:0]   delay_sr;

    always_ff @(posedge ck or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt <= '0;
            sck <= 1'b0;
            bit_en <= 1'b0;
            frame_posn <= '0;
        end else begin
            bit_en <= 1'b0;
            if (div_cnt == DIV_W'(I2S_DIVIDER - 1)) begin
                div_cnt <= '0;
                // Falling sck edge starts the next slot
                sck <= 1'b0;
                bit_en <= 1'b1;
                frame_posn <= frame_posn + 1'b1;
            end else begin
                div_cnt <= div_cnt + 1'b1;
                if (div_cnt == DIV_W'(I2S_DIVIDER / 2 - 1)) begin
                    sck <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge ck or negedge arst_n) begin
        if (!arst_n) begin
            delay_sr <= '0;
        end else begin
            delay_sr <= {delay_sr[DLY-2:0], bit_en};
        end
    end

    assign sample_en = delay_sr[DLY-1];

    // Left half of the frame while low
    assign ws = frame_posn[5];

endmodule

// File: i2s_tx.sv
`timescale 1ns/1ps

module i2s_tx (
    input  logic                ck,
    input  logic                arst_n,
    input  logic                bit_en,
    input  audio_pkg::posn_t    frame_posn,
    input  audio_pkg::sample_t  left,
    input  audio_pkg::sample_t  right,
    output logic                sd
);

    audio_pkg::sample_t shift_q;
    audio_pkg::sample_t right_hold;
    logic               data_slot;

    assign data_slot = (frame_posn[4:0] != 5'd0) && (frame_posn[4:0] <= 5'd16);

    always_ff @(posedge ck or negedge arst_n) begin
        if (!arst_n) begin
            shift_q <= '0;
            right_hold <= '0;
            sd <= 1'b0;
        end else if (bit_en) begin
            if (frame_posn == 6'd0) begin
                // Both halves of a frame come from the same snapshot
                shift_q <= left;
                right_hold <= right;
                sd <= 1'b0;
            end else if (frame_posn == 6'd32) begin
                shift_q <= right_hold;
                sd <= 1'b0;
            end else if (data_slot) begin
                sd <= shift_q[15];
                shift_q <= {shift_q[14:0], 1'b0};
            end else begin
                sd <= 1'b0;
            end
        end
    end

endmodule

// File: src.f
audio_pkg.sv
i2s_timing.sv
i2s_rx.sv
i2s_tx.sv
frame_capture.sv
audio_ram.sv
host_regs.sv
audio_engine.sv
audio_engine_properties.sv
tb_audio_engine.sv

// File: tb_audio_engine.sv
`timescale 1ns/1ps

module tb_audio_engine;

    localparam audio_pkg::cs_t BASE = 8'h60;
    localparam int DIV = 16;
    localparam int FRAME_CYCLES = 64 * DIV;
    localparam audio_pkg::cs_t CS_STATUS = BASE + audio_pkg::OFFSET_STATUS;
    localparam audio_pkg::cs_t CS_AUDIO = BASE + audio_pkg::OFFSET_AUDIO;

    logic ck;
    logic arst_n;
    logic bus_cyc;
    logic bus_we;
    audio_pkg::word_t bus_adr;
    audio_pkg::word_t bus_dat;
    logic sd_in0;
    logic sd_in1;
    logic sd_in2;
    logic sd_in3;
    logic ack;
    audio_pkg::word_t rdt;
    logic sck;
    logic ws;
    logic sd_out;
    logic ready;

    // I2S source model and the expected RAM contents
    audio_pkg::sample_t cur [8];
    audio_pkg::sample_t last_cap [8];
    audio_pkg::sample_t exp_mem [8][256];
    audio_pkg::frame_t exp_frame;
    audio_pkg::frame_t exp_count;
    logic [6:0] ctrl_shadow;
    int slot;
    logic ws_prev;
    time last_fall;
    integer seed;
    int errors;
    int checks;

    audio_engine #(.BASE_ADDR(BASE), .I2S_DIVIDER(DIV)) i_audio_engine (
        .ck(ck), .arst_n(arst_n), .bus_cyc(bus_cyc), .bus_we(bus_we),
        .bus_adr(bus_adr), .bus_dat(bus_dat), .sd_in0(sd_in0), .sd_in1(sd_in1),
        .sd_in2(sd_in2), .sd_in3(sd_in3), .ack(ack), .rdt(rdt), .sck(sck),
        .ws(ws), .sd_out(sd_out), .ready(ready)
    );

    initial begin
        ck = 1'b0;
        forever #4 ck = ~ck;
    end

    task automatic check_sample(input string name, input audio_pkg::sample_t exp,
                                input audio_pkg::sample_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_word(input string name, input audio_pkg::word_t exp,
                              input audio_pkg::word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    function automatic audio_pkg::word_t audio_adr(input audio_pkg::chan_t ch,
                                                   input audio_pkg::frame_t fr);
        return {CS_AUDIO, 11'd0, ch, fr, 2'b00};
    endfunction

    function automatic audio_pkg::word_t status_adr(input int w);
        return {CS_STATUS, 20'd0, 2'(w), 2'b00};
    endfunction

    // Status word layout: host mode, capture count, frame index
    function automatic audio_pkg::word_t status_word(input logic hm,
            input audio_pkg::frame_t count, input audio_pkg::frame_t fr);
        return {15'd0, hm, count, fr};
    endfunction

    task automatic new_frame_samples();
        integer rnd;
        int ch;
        rnd = $random(seed);
        for (ch = 0; ch < 8; ch++) begin
            cur[ch] = {3'(ch), rnd[12:0] ^ 13'(ch * 37)};
        end
    endtask

    task automatic frame_start();
        int ch;
        // Samples of the finished frame land at the next index down
        if (!ctrl_shadow[0]) begin
            exp_frame = exp_frame - 1'b1;
            exp_count = exp_count + 1'b1;
            for (ch = 0; ch < 8; ch++) begin
                exp_mem[ch][exp_frame] = cur[ch];
                last_cap[ch] = cur[ch];
            end
        end
        new_frame_samples();
    endtask

    // MSB first in slots 1..16 (left) and 33..48 (right)
    function automatic logic line_bit(input int line, input int s);
        if (s >= 1 && s <= 16) begin
            return cur[2 * line][16 - s];
        end else if (s >= 33 && s <= 48) begin
            return cur[2 * line + 1][48 - s];
        end
        return 1'b0;
    endfunction

    always @(negedge sck) begin
        #1;
        if (arst_n) begin
            // One sck period per slot
            if (last_fall != 0) begin
                check_word("sck period", audio_pkg::word_t'(8 * DIV),
                           audio_pkg::word_t'($time - last_fall));
            end
            last_fall = $time;
            if (ws_prev && !ws) begin
                slot = 0;
                frame_start();
            end else begin
                slot = slot + 1;
            end
            ws_prev = ws;
            // Right half of the frame is slots 32..63
            check_bit($sformatf("ws in slot %0d", slot), slot >= 32, ws);
            sd_in0 = line_bit(0, slot);
            sd_in1 = line_bit(1, slot);
            sd_in2 = line_bit(2, slot);
            sd_in3 = line_bit(3, slot);
        end
    end

    task automatic bus_access(input logic we, input audio_pkg::word_t adr,
                              input audio_pkg::word_t dat, input int max_cycles,
                              output logic got_ack, output audio_pkg::word_t data);
        int n;
        bus_cyc = 1'b1;
        bus_we = we;
        bus_adr = adr;
        bus_dat = dat;
        got_ack = 1'b0;
        data = '0;
        n = 0;
        while (!got_ack && n < max_cycles) begin
            @(posedge ck);
            #1;
            n++;
            if (ack) begin
                got_ack = 1'b1;
                data = rdt;
            end
        end
        bus_cyc = 1'b0;
        bus_we = 1'b0;
        // Idle cycle between requests
        @(posedge ck);
        #1;
    endtask

    task automatic bus_read(input audio_pkg::word_t adr, output audio_pkg::word_t data);
        logic got;
        bus_access(1'b0, adr, '0, 20, got, data);
        if (!got) begin
            errors++;
            $display("ERROR: no ack for read at address %h", adr);
        end
    endtask

    task automatic bus_write(input audio_pkg::word_t adr, input audio_pkg::word_t dat);
        logic got;
        audio_pkg::word_t unused;
        bus_access(1'b1, adr, dat, 20, got, unused);
        if (!got) begin
            errors++;
            $display("ERROR: no ack for write at address %h", adr);
        end
    endtask

    task automatic write_ctrl(input logic [6:0] val);
        bus_write(status_adr(0), {25'd0, val});
        ctrl_shadow = val;
    endtask

    task automatic wait_ready();
        int n;
        logic seen;
        seen = 1'b0;
        for (n = 0; n < 2 * FRAME_CYCLES + 100 && !seen; n++) begin
            @(posedge ck);
            #1;
            seen = ready;
        end
        if (!seen) begin
            errors++;
            $display("ERROR: timed out waiting for the ready pulse");
        end
    endtask

    // Collect one full frame of sd_out, starting at the next frame boundary
    task automatic decode_sd_out(output audio_pkg::sample_t l, output audio_pkg::sample_t r);
        int n;
        int phase;
        logic sck_prev;
        l = '0;
        r = '0;
        phase = 0;
        sck_prev = sck;
        for (n = 0; n < 3 * FRAME_CYCLES && phase != 3; n++) begin
            @(posedge ck);
            #1;
            if (phase == 0 && slot != 0) begin
                phase = 1;
            end else if (phase == 1 && slot == 0) begin
                phase = 2;
            end else if (phase == 2 && sck && !sck_prev) begin
                if (slot >= 1 && slot <= 16) begin
                    l = {l[14:0], sd_out};
                end else if (slot >= 33 && slot <= 48) begin
                    r = {r[14:0], sd_out};
                end else if (slot == 49) begin
                    phase = 3;
                end
            end
            sck_prev = sck;
        end
        if (phase != 3) begin
            errors++;
            $display("ERROR: timed out decoding a frame from sd_out");
        end
    endtask

    task automatic test_reset_state();
        audio_pkg::word_t data;
        logic seen_high;
        int n;
        bus_read(status_adr(1), data);
        check_word("test_reset_state status", status_word(1'b0, 8'd0, 8'd0), data);
        bus_read(status_adr(0), data);
        check_word("test_reset_state control", '0, data);
        seen_high = 1'b0;
        for (n = 0; n < 200; n++) begin
            @(posedge ck);
            #1;
            if (sd_out !== 1'b0) begin
                seen_high = 1'b1;
            end
        end
        check_bit("test_reset_state sd_out", 1'b0, seen_high);
    endtask

    task automatic test_capture();
        audio_pkg::word_t data;
        int f;
        int ch;
        repeat (3) wait_ready();
        bus_read(status_adr(1), data);
        check_word("test_capture status", status_word(1'b0, 8'd3, 8'd253), data);
        for (f = 255; f >= 253; f--) begin
            for (ch = 0; ch < 8; ch++) begin
                bus_read(audio_adr(3'(ch), 8'(f)), data);
                check_sample($sformatf("test_capture ch%0d frame %0d", ch, f),
                             exp_mem[ch][f], data[15:0]);
            end
        end
    endtask

    task automatic test_monitor_out();
        audio_pkg::sample_t exp_l;
        audio_pkg::sample_t exp_r;
        audio_pkg::sample_t got_l;
        audio_pkg::sample_t got_r;
        wait_ready();
        // Right select 2, left select 5
        write_ctrl({3'd2, 3'd5, 1'b0});
        wait_ready();
        exp_l = last_cap[5];
        exp_r = last_cap[2];
        decode_sd_out(got_l, got_r);
        check_sample("test_monitor_out left", exp_l, got_l);
        check_sample("test_monitor_out right", exp_r, got_r);
    endtask

    task automatic test_host_mode();
        audio_pkg::word_t data;
        audio_pkg::sample_t wval [4];
        logic saw_ready;
        int i;
        wait_ready();
        write_ctrl(ctrl_shadow | 7'd1);
        bus_read(status_adr(1), data);
        check_word("test_host_mode status on entry",
                   status_word(1'b1, exp_count, exp_frame), data);
        for (i = 0; i < 4; i++) begin
            wval[i] = 16'($random(seed));
            bus_write(audio_adr(3'(i), 8'(16 + i)), {16'd0, wval[i]});
        end
        for (i = 0; i < 4; i++) begin
            bus_read(audio_adr(3'(i), 8'(16 + i)), data);
            check_sample($sformatf("test_host_mode word %0d", i), wval[i], data[15:0]);
        end
        saw_ready = 1'b0;
        for (i = 0; i < 2 * FRAME_CYCLES + 64; i++) begin
            @(posedge ck);
            #1;
            if (ready) begin
                saw_ready = 1'b1;
            end
        end
        if (saw_ready) begin
            errors++;
            $display("ERROR: ready pulsed while host mode was set");
        end
        bus_read(status_adr(1), data);
        check_word("test_host_mode status held",
                   status_word(1'b1, exp_count, exp_frame), data);
        write_ctrl(ctrl_shadow & 7'h7e);
        wait_ready();
        bus_read(status_adr(1), data);
        check_word("test_host_mode status resumed",
                   status_word(1'b0, exp_count, exp_frame), data);
        bus_read(audio_adr(3'd4, exp_frame), data);
        check_sample("test_host_mode resumed ch4", exp_mem[4][exp_frame], data[15:0]);
    endtask

    task automatic test_bad_address();
        audio_pkg::word_t data;
        logic got;
        bus_access(1'b0, {8'h70, 24'd0}, '0, 8, got, data);
        if (got) begin
            errors++;
            $display("ERROR: undecoded window at 0x70 was acknowledged");
        end else begin
            $display("test_bad_address: no ack within 8 cycles for the undecoded window");
        end
        bus_read(status_adr(3), data);
        check_word("test_bad_address status word 3", '0, data);
    endtask

    initial begin
        arst_n = 1'b0;
        bus_cyc = 1'b0;
        bus_we = 1'b0;
        bus_adr = '0;
        bus_dat = '0;
        sd_in0 = 1'b0;
        sd_in1 = 1'b0;
        sd_in2 = 1'b0;
        sd_in3 = 1'b0;
        seed = 37042;
        errors = 0;
        checks = 0;
        slot = 0;
        ws_prev = 1'b0;
        last_fall = 0;
        ctrl_shadow = '0;
        exp_frame = '0;
        exp_count = '0;
        new_frame_samples();
        repeat (10) @(posedge ck);
        #1;
        arst_n = 1'b1;

        test_reset_state();
        test_capture();
        test_monitor_out();
        test_host_mode();
        test_bad_address();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
